//--- src/ising_data_pkg.sv
//****************************************
// Ising data package
// widths and vector types for spins,
// coupling weights, biases and fields
//****************************************

package ising_data_pkg;

  // problem size
  localparam int unsigned NumSpins     = 8;
  localparam int unsigned SpinIdxWidth = 3;  // log2 of NumSpins

  // arithmetic widths
  localparam int unsigned WeightWidth = 4;
  localparam int unsigned BiasWidth   = 6;
  // worst case |field| is 7*8 + 32 = 88, fits a signed byte
  localparam int unsigned FieldWidth  = 8;

  // one bit per spin, 1 is +1 and 0 is -1
  typedef logic [NumSpins-1:0] spins_t;

  // row or column address into the coupling matrix
  typedef logic [SpinIdxWidth-1:0] spin_idx_t;

  // signed coupling weight J_kj
  typedef logic signed [WeightWidth-1:0] weight_t;

  // signed per-spin bias h_k
  typedef logic signed [BiasWidth-1:0] bias_t;

  // signed local field of one spin
  typedef logic signed [FieldWidth-1:0] field_t;

endpackage : ising_data_pkg

//--- src/ising_ctrl_pkg.sv
//****************************************
// Ising control package
// run FSM state, sweep, temperature and
// LFSR types and constants
//****************************************

package ising_ctrl_pkg;

  // noise source
  localparam int unsigned LfsrWidth = 16;
  localparam logic [LfsrWidth-1:0] LfsrZeroSubst = 16'h0001;  // an all-zero LFSR would lock up

  localparam int unsigned SweepWidth = 8;
  localparam int unsigned TempWidth  = 8;

  // number of full passes over the spin vector
  typedef logic [SweepWidth-1:0] sweeps_t;

  // flip threshold, compared against the LFSR low byte
  typedef logic [TempWidth-1:0] temp_t;

  // LFSR state and seed
  typedef logic [LfsrWidth-1:0] lfsr_t;

  // run FSM
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } ctrl_state_t;

endpackage : ising_ctrl_pkg

//--- src/ising_field_unit.sv
//****************************************
// Ising field unit
// holds the J matrix and h vector, sums
// the local field of the addressed spin
//****************************************

`timescale 1ns/1ns

module ising_field_unit (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // coupling and bias write strobes
  input  logic                      j_we_i,
  input  ising_data_pkg::spin_idx_t j_row_i,
  input  ising_data_pkg::spin_idx_t j_col_i,
  input  ising_data_pkg::weight_t   j_data_i,
  input  logic                      h_we_i,
  input  ising_data_pkg::bias_t     h_data_i,
  // current spin state and addressed spin
  input  ising_data_pkg::spins_t    spins_i,
  input  ising_data_pkg::spin_idx_t spin_idx_i,
  output ising_data_pkg::field_t    field_o
);

  ising_data_pkg::weight_t j_q [ising_data_pkg::NumSpins][ising_data_pkg::NumSpins];
  ising_data_pkg::bias_t   h_q [ising_data_pkg::NumSpins];

  // coupling matrix, one weight per row/column pair
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < ising_data_pkg::NumSpins; r++) begin
        for (int c = 0; c < ising_data_pkg::NumSpins; c++) begin
          j_q[r][c] <= '0;
        end
      end
    end else if (j_we_i) begin
      j_q[j_row_i][j_col_i] <= j_data_i;
    end
  end

  // bias vector, addressed by the row port
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < ising_data_pkg::NumSpins; r++) begin
        h_q[r] <= '0;
      end
    end else if (h_we_i) begin
      h_q[j_row_i] <= h_data_i;
    end
  end

  // h_k + sum over j != k of J_kj * s_j, with s_j = +1/-1
  always_comb begin : field_sum
    ising_data_pkg::field_t acc;
    ising_data_pkg::field_t term;
    acc = ising_data_pkg::field_t'(h_q[spin_idx_i]);  // sign extended
    for (int j = 0; j < ising_data_pkg::NumSpins; j++) begin
      term = ising_data_pkg::field_t'(j_q[spin_idx_i][j]);
      if (ising_data_pkg::spin_idx_t'(j) != spin_idx_i) begin
        if (spins_i[j]) begin
          acc = acc + term;
        end else begin
          acc = acc - term;  // spin at -1
        end
      end
    end
    field_o = acc;
  end

endmodule : ising_field_unit

//--- src/anneal_noise_gen.sv
//****************************************
// Annealing noise generator
// 16-bit Fibonacci LFSR and temperature
// compare giving the spin flip flag
//****************************************

`timescale 1ns/1ns

module anneal_noise_gen (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  seed_load_i,
  input  ising_ctrl_pkg::lfsr_t seed_i,
  input  logic                  step_i,   // one shift per spin update
  input  ising_ctrl_pkg::temp_t temp_i,
  output logic                  flip_o
);

  ising_ctrl_pkg::lfsr_t lfsr_q;
  logic                  feedback;

  // taps 16, 14, 13, 11
  assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= ising_ctrl_pkg::LfsrZeroSubst;
    end else if (seed_load_i) begin
      if (seed_i == '0) begin
        lfsr_q <= ising_ctrl_pkg::LfsrZeroSubst;  // keep the LFSR out of the lockup state
      end else begin
        lfsr_q <= seed_i;
      end
    end else if (step_i) begin
      lfsr_q <= {lfsr_q[ising_ctrl_pkg::LfsrWidth-2:0], feedback};  // shift toward msb
    end
  end

  // strict compare, temperature 0 never flips
  assign flip_o = (lfsr_q[7:0] < temp_i);

endmodule : anneal_noise_gen

//--- src/spin_update_ctrl.sv
//****************************************
// Spin update controller
// run FSM, spin and sweep counters, and
// the Gauss-Seidel spin register
//****************************************

`timescale 1ns/1ns

module spin_update_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  ising_ctrl_pkg::sweeps_t   sweeps_i,
  input  ising_data_pkg::spins_t    init_spins_i,
  input  ising_data_pkg::field_t    field_i,   // field of spin_idx_o, same cycle
  input  logic                      flip_i,
  output ising_data_pkg::spin_idx_t spin_idx_o,
  output ising_data_pkg::spins_t    spins_o,
  output logic                      seed_load_o,
  output logic                      step_o,
  output logic                      busy_o,
  output logic                      done_o
);

  ising_ctrl_pkg::ctrl_state_t state_q, state_d;
  ising_data_pkg::spin_idx_t   idx_q;
  ising_ctrl_pkg::sweeps_t     sweep_cnt_q;
  ising_data_pkg::spins_t      spins_q;
  logic                        start_ok;
  logic                        last_idx;
  logic                        new_spin;
  logic                        busy_q;
  logic                        done_q;

  assign start_ok = start_i && (state_q == ising_ctrl_pkg::IDLE);
  assign last_idx = (idx_q == ising_data_pkg::spin_idx_t'(ising_data_pkg::NumSpins - 1));

  // sign of the field, then optional noise flip
  assign new_spin = ~field_i[ising_data_pkg::FieldWidth-1] ^ flip_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ising_ctrl_pkg::IDLE: begin
        if (start_i) begin
          state_d = (sweeps_i == '0) ? ising_ctrl_pkg::DONE : ising_ctrl_pkg::RUN;
        end
      end
      ising_ctrl_pkg::RUN: begin
        if (last_idx && sweep_cnt_q == ising_ctrl_pkg::sweeps_t'(1)) begin
          state_d = ising_ctrl_pkg::DONE;
        end
      end
      ising_ctrl_pkg::DONE: state_d = ising_ctrl_pkg::IDLE;  // single cycle
      default: state_d = ising_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ising_ctrl_pkg::IDLE;
      idx_q       <= '0;
      sweep_cnt_q <= '0;
      spins_q     <= '0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        idx_q       <= '0;
        sweep_cnt_q <= sweeps_i;
        spins_q     <= init_spins_i;
      end else if (state_q == ising_ctrl_pkg::RUN) begin
        spins_q[idx_q] <= new_spin;
        idx_q          <= idx_q + 1'b1;  // wraps after the last spin
        if (last_idx) begin
          sweep_cnt_q <= sweep_cnt_q - 1'b1;
        end
      end
    end
  end

  // status flags lag the FSM by one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      busy_q <= (state_q == ising_ctrl_pkg::RUN);
      done_q <= (state_q == ising_ctrl_pkg::DONE);
    end
  end

  assign spin_idx_o  = idx_q;
  assign spins_o     = spins_q;
  assign seed_load_o = start_ok;
  assign step_o      = (state_q == ising_ctrl_pkg::RUN);  // lfsr moves on after every use
  assign busy_o      = busy_q;
  assign done_o      = done_q;

endmodule : spin_update_ctrl

//--- src/ising_core.sv
//****************************************
// Ising core
// digital spin-update engine top level
//****************************************

`timescale 1ns/1ns

module ising_core (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      j_we_i,
  input  ising_data_pkg::spin_idx_t j_row_i,
  input  ising_data_pkg::spin_idx_t j_col_i,
  input  ising_data_pkg::weight_t   j_data_i,
  input  logic                      h_we_i,
  input  ising_data_pkg::bias_t     h_data_i,
  input  logic                      start_i,
  input  ising_ctrl_pkg::sweeps_t   sweeps_i,
  input  ising_data_pkg::spins_t    init_spins_i,
  input  ising_ctrl_pkg::lfsr_t     seed_i,
  input  ising_ctrl_pkg::temp_t     temp_i,
  output logic                      busy_o,
  output logic                      done_o,
  output ising_data_pkg::spins_t    spins_o
);

  ising_data_pkg::field_t    field;
  ising_data_pkg::spin_idx_t spin_idx;
  ising_data_pkg::spins_t    spins;
  logic                      flip;
  logic                      seed_load;
  logic                      step;

  ising_field_unit u_field_unit (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .j_we_i     (j_we_i),
    .j_row_i    (j_row_i),
    .j_col_i    (j_col_i),
    .j_data_i   (j_data_i),
    .h_we_i     (h_we_i),
    .h_data_i   (h_data_i),
    .spins_i    (spins),
    .spin_idx_i (spin_idx),
    .field_o    (field)
  );

  anneal_noise_gen u_noise_gen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .seed_load_i (seed_load),
    .seed_i      (seed_i),
    .step_i      (step),
    .temp_i      (temp_i),
    .flip_o      (flip)
  );

  // combines field sign and flip flag, feeds index and spins back
  spin_update_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .sweeps_i     (sweeps_i),
    .init_spins_i (init_spins_i),
    .field_i      (field),
    .flip_i       (flip),
    .spin_idx_o   (spin_idx),
    .spins_o      (spins),
    .seed_load_o  (seed_load),
    .step_o       (step),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  assign spins_o = spins;

endmodule : ising_core

//--- testbench/fixture_ising_core.sv
//****************************************
// Ising core test fixture
// clock, reset and the DUT instance
//****************************************

`timescale 1ns/1ns

module fixture_ising_core (
  output logic                      clk_o,
  output logic                      rst_n_o,
  input  logic                      j_we_i,
  input  ising_data_pkg::spin_idx_t j_row_i,
  input  ising_data_pkg::spin_idx_t j_col_i,
  input  ising_data_pkg::weight_t   j_data_i,
  input  logic                      h_we_i,
  input  ising_data_pkg::bias_t     h_data_i,
  input  logic                      start_i,
  input  ising_ctrl_pkg::sweeps_t   sweeps_i,
  input  ising_data_pkg::spins_t    init_spins_i,
  input  ising_ctrl_pkg::lfsr_t     seed_i,
  input  ising_ctrl_pkg::temp_t     temp_i,
  output logic                      busy_o,
  output logic                      done_o,
  output ising_data_pkg::spins_t    spins_o
);

  // 40 ns clock
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset held for 10 cycles, released away from the active edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

  ising_core u_ising_core (
    .clk_i        (clk_o),
    .rst_n_i      (rst_n_o),
    .j_we_i       (j_we_i),
    .j_row_i      (j_row_i),
    .j_col_i      (j_col_i),
    .j_data_i     (j_data_i),
    .h_we_i       (h_we_i),
    .h_data_i     (h_data_i),
    .start_i      (start_i),
    .sweeps_i     (sweeps_i),
    .init_spins_i (init_spins_i),
    .seed_i       (seed_i),
    .temp_i       (temp_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .spins_o      (spins_o)
  );

endmodule : fixture_ising_core

//--- testbench/tb_ising_core.sv
//****************************************
// Ising core testbench
// directed tests against a reference
// model of the spin update rule
//****************************************

`timescale 1ns/1ns

module tb_ising_core;

  logic                      clk;
  logic                      rst_n;
  logic                      j_we;
  ising_data_pkg::spin_idx_t j_row;
  ising_data_pkg::spin_idx_t j_col;
  ising_data_pkg::weight_t   j_data;
  logic                      h_we;
  ising_data_pkg::bias_t     h_data;
  logic                      start;
  ising_ctrl_pkg::sweeps_t   sweeps;
  ising_data_pkg::spins_t    init_spins;
  ising_ctrl_pkg::lfsr_t     seed;
  ising_ctrl_pkg::temp_t     temp;
  logic                      busy;
  logic                      done;
  ising_data_pkg::spins_t    spins;

  int rand_seed;
  int j_model [8][8];  // couplings as written
  int h_model [8];

  fixture_ising_core u_fixture (
    .clk_o        (clk),
    .rst_n_o      (rst_n),
    .j_we_i       (j_we),
    .j_row_i      (j_row),
    .j_col_i      (j_col),
    .j_data_i     (j_data),
    .h_we_i       (h_we),
    .h_data_i     (h_data),
    .start_i      (start),
    .sweeps_i     (sweeps),
    .init_spins_i (init_spins),
    .seed_i       (seed),
    .temp_i       (temp),
    .busy_o       (busy),
    .done_o       (done),
    .spins_o      (spins)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_spins(input string what, input ising_data_pkg::spins_t got,
                              input ising_data_pkg::spins_t exp);
    assert (got === exp)
      else abort_run($sformatf("FAIL @%0t: %s spins %h, expected %h", $time, what, got, exp));
  endtask

  task automatic write_coupling(input int r, input int c, input int value);
    @(negedge clk);
    j_we   = 1'b1;
    j_row  = r[2:0];
    j_col  = c[2:0];
    j_data = value[3:0];
    @(negedge clk);
    j_we = 1'b0;
    j_model[r][c] = value;
  endtask

  task automatic write_bias(input int r, input int value);
    @(negedge clk);
    h_we   = 1'b1;
    j_row  = r[2:0];
    h_data = value[5:0];
    @(negedge clk);
    h_we = 1'b0;
    h_model[r] = value;
  endtask

  // Gauss-Seidel sweeps with the field sign rule and LFSR noise
  task automatic predict_spins(input ising_data_pkg::spins_t init,
                               input ising_ctrl_pkg::lfsr_t seed_in,
                               input ising_ctrl_pkg::temp_t t,
                               input ising_ctrl_pkg::sweeps_t n,
                               output ising_data_pkg::spins_t res);
    ising_data_pkg::spins_t s;
    logic [15:0] lfsr;
    int field;
    logic spin_new;
    s = init;
    lfsr = (seed_in == 16'h0000) ? 16'h0001 : seed_in;
    for (int sw = 0; sw < int'(n); sw++) begin
      for (int k = 0; k < 8; k++) begin
        field = h_model[k];
        for (int j = 0; j < 8; j++) begin
          if (j != k) begin
            field += s[j] ? j_model[k][j] : -j_model[k][j];
          end
        end
        spin_new = (field >= 0);
        if (lfsr[7:0] < t) begin
          spin_new = ~spin_new;  // annealing flip
        end
        s[k] = spin_new;
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
    end
    res = s;
  endtask

  // start pulse, then wait for done; restart_at pulses start again after that edge
  task automatic run_engine(input ising_data_pkg::spins_t init,
                            input ising_ctrl_pkg::lfsr_t seed_in,
                            input ising_ctrl_pkg::temp_t t,
                            input ising_ctrl_pkg::sweeps_t n,
                            input int restart_at,
                            input ising_data_pkg::spins_t exp,
                            input string what);
    int cycles;
    @(negedge clk);
    start      = 1'b1;
    sweeps     = n;
    init_spins = init;
    seed       = seed_in;
    temp       = t;
    @(negedge clk);
    start  = 1'b0;
    cycles = 0;  // start edge is edge 0
    while (done !== 1'b1) begin
      if (cycles > 8 * int'(n) + 10) begin
        abort_run("done_o never came after the start pulse");
      end
      @(negedge clk);
      cycles++;
      start = (cycles == restart_at);
      if (start) begin
        init_spins = ~init;  // must be ignored while busy
        sweeps     = 8'd1;
      end
      if (done !== 1'b1) begin
        assert (busy === 1'b1)
          else abort_run($sformatf("FAIL @%0t: busy_o low during run", $time));
      end
    end
    start = 1'b0;
    assert (cycles == 8 * int'(n) + 1)
      else abort_run($sformatf("FAIL @%0t: done_o after %0d cycles", $time, cycles));
    assert (busy === 1'b0)
      else abort_run($sformatf("FAIL @%0t: busy_o high with done_o", $time));
    expect_spins(what, spins, exp);
    @(negedge clk);
    assert (done === 1'b0)
      else abort_run($sformatf("FAIL @%0t: done_o longer than one cycle", $time));
    expect_spins({what, " held"}, spins, exp);
  endtask

  task automatic check_reset_state();
    assert (busy === 1'b0 && done === 1'b0)
      else abort_run($sformatf("FAIL @%0t: busy_o or done_o set after reset", $time));
    expect_spins("reset", spins, 8'h00);
  endtask

  task automatic bias_only_sweep();
    ising_data_pkg::spins_t exp;
    int hv;
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < 8; c++) begin
        write_coupling(r, c, 0);
      end
    end
    for (int r = 0; r < 8; r++) begin
      hv = $random(rand_seed) % 32;
      write_bias(r, hv);
      exp[r] = (hv >= 0);
    end
    run_engine(8'h5a, 16'hace1, 8'd0, 8'd1, -1, exp, "bias only");
  endtask

  task automatic ferromagnet_sweeps();
    ising_data_pkg::spins_t model;
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < 8; c++) begin
        write_coupling(r, c, (r == c) ? -8 : 1);  // diagonal must be skipped
      end
      write_bias(r, 0);
    end
    predict_spins(8'b1011_0010, 16'h1234, 8'd0, 8'd3, model);
    run_engine(8'b1011_0010, 16'h1234, 8'd0, 8'd3, -1, model, "ferromagnet");
    assert (spins === 8'h00 || spins === 8'hff)
      else abort_run($sformatf("FAIL @%0t: spins %h not aligned", $time, spins));
  endtask

  task automatic annealing_noise();
    ising_data_pkg::spins_t model;
    ising_data_pkg::spins_t init;
    ising_ctrl_pkg::lfsr_t sd;
    ising_ctrl_pkg::temp_t t;
    ising_ctrl_pkg::sweeps_t n;
    int v;
    for (int round = 0; round < 3; round++) begin
      for (int r = 0; r < 8; r++) begin
        for (int c = 0; c < 8; c++) begin
          write_coupling(r, c, $random(rand_seed) % 8);
        end
        write_bias(r, $random(rand_seed) % 32);
      end
      v    = $random(rand_seed);
      init = v[7:0];
      sd   = (round == 0) ? 16'h0000 : v[31:16];  // zero seed on the first round
      v    = $random(rand_seed);
      t    = (round == 1) ? 8'd255 : v[7:0];
      n    = 8'd2 + v[9:8];
      predict_spins(init, sd, t, n, model);
      run_engine(init, sd, t, n, -1, model, $sformatf("anneal round %0d", round));
    end
  endtask

  task automatic control_corner_cases();
    ising_data_pkg::spins_t model;
    run_engine(8'hc3, 16'h0000, 8'd10, 8'd0, -1, 8'hc3, "zero sweeps");
    predict_spins(8'h96, 16'hbeef, 8'd40, 8'd2, model);
    run_engine(8'h96, 16'hbeef, 8'd40, 8'd2, 4, model, "start while busy");
  endtask

  initial begin
    int wait_cnt;
    j_we       = 1'b0;
    j_row      = '0;
    j_col      = '0;
    j_data     = '0;
    h_we       = 1'b0;
    h_data     = '0;
    start      = 1'b0;
    sweeps     = '0;
    init_spins = '0;
    seed       = '0;
    temp       = '0;
    rand_seed  = 32'h329dce74;
    for (int r = 0; r < 8; r++) begin
      h_model[r] = 0;
      for (int c = 0; c < 8; c++) begin
        j_model[r][c] = 0;
      end
    end
    wait_cnt = 0;
    while (rst_n !== 1'b1) begin
      if (wait_cnt > 40) begin
        abort_run("reset was never released");
      end
      @(negedge clk);
      wait_cnt++;
    end
    check_reset_state();
    bias_only_sweep();
    ferromagnet_sweeps();
    annealing_noise();
    control_corner_cases();
    $display("Result: PASSED");
    $finish;
  end

endmodule : tb_ising_core

//--- sources.f
src/ising_data_pkg.sv
src/ising_ctrl_pkg.sv
src/ising_field_unit.sv
src/anneal_noise_gen.sv
src/spin_update_ctrl.sv
src/ising_core.sv
testbench/fixture_ising_core.sv
testbench/tb_ising_core.sv

//--- Bender.yml
package:
  name: ising_core

sources:
  # packages first, then leaf modules, then the top level
  - src/ising_data_pkg.sv
  - src/ising_ctrl_pkg.sv
  - src/ising_field_unit.sv
  - src/anneal_noise_gen.sv
  - src/spin_update_ctrl.sv
  - src/ising_core.sv

  - target: test
    files:
      - testbench/fixture_ising_core.sv
      - testbench/tb_ising_core.sv
